// File: sources.f
source/l2_mem_pkg.sv
source/l2_sram_cut.sv
source/l2_bank_arbiter.sv
source/l2_interconnect.sv
source/l2_mem_bank_array.sv
source/l2_cfg_regs.sv
source/l2_mem.sv
verif/tb_l2_mem.sv

// File: run_sim.sh
#!/bin/sh
# build the L2 scratchpad testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_l2_mem -f sources.f -o tb_l2_mem
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_l2_mem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi

if ! grep -q "SIMULATION PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0

// File: verif/tb_l2_mem.sv
// L2 scratchpad memory testbench
// table-driven port traffic checked against a byte-addressed reference model,
// plus arbitration order, row selection and the conflict counter
`timescale 1ns/1ps

module tb_l2_mem
  import l2_mem_pkg::*;
();

  localparam logic [1:0] OP_IDLE   = 2'd0;
  localparam logic [1:0] OP_RD     = 2'd1;
  localparam logic [1:0] OP_WR     = 2'd2;
  localparam logic [1:0] CFG_NONE  = 2'd0;
  localparam logic [1:0] CFG_MODE  = 2'd1;
  localparam logic [1:0] CFG_COUNT = 2'd2;

  // exp_gnt is {a, b} in the first cycle of the step
  typedef struct packed {
    logic [1:0] cfg_op;
    arb_mode_t  mode;
    logic [1:0] a_op;
    addr_t      a_addr;
    data_t      a_data;
    strb_t      a_be;
    logic [1:0] b_op;
    addr_t      b_addr;
    data_t      b_data;
    strb_t      b_be;
    logic [1:0] exp_gnt;
  } step_t;

  logic      clk_i = 1'b0;
  logic      rst_n_i;
  logic      a_req_i, a_we_i, a_gnt_o, a_rvalid_o;
  logic      b_req_i, b_we_i, b_gnt_o, b_rvalid_o;
  addr_t     a_addr_i, b_addr_i;
  data_t     a_wdata_i, b_wdata_i, a_rdata_o, b_rdata_o;
  strb_t     a_be_i, b_be_i;
  logic      cfg_we_i;
  cfg_addr_t cfg_addr_i;
  data_t     cfg_wdata_i, cfg_rdata_o;

  step_t      steps[$];
  string      names[$];
  logic [7:0] ref_mem [1 << ADDR_W];
  integer     seed;
  int         tally, step_errs, fail_tests, cycles, max_cycles = 100;

  l2_mem dut_i (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > max_cycles) begin
      $display("timeout after %0d cycles, a grant or read return never came", max_cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic data_t model_read(addr_t addr);
    data_t word;
    for (int i = 0; i < STRB_W; i++) begin
      word[8*i +: 8] = ref_mem[{addr[ADDR_W-1:2], 2'(i)}];
    end
    return word;
  endfunction

  task automatic model_write(addr_t addr, data_t data, strb_t be);
    for (int i = 0; i < STRB_W; i++) begin
      if (be[i]) begin
        ref_mem[{addr[ADDR_W-1:2], 2'(i)}] = data[8*i +: 8];
      end
    end
  endtask

  task automatic check_data(string name, data_t exp, data_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      step_errs++;
    end
  endtask

  task automatic check_gnt(string name, logic [1:0] exp, logic [1:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s: gnt {a,b} expected %b, actual %b", name, exp, act);
      step_errs++;
    end
  endtask

  task automatic check_count(string name, data_t exp, data_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: conflict count expected %0d, actual %0d", name, exp, act);
      step_errs++;
    end
  endtask

  task automatic check_retries(string name, int exp, int act);
    if (act != exp) begin
      $display("[FAIL] %s: retries expected %0d, actual %0d", name, exp, act);
      step_errs++;
    end
  endtask

  // read return one cycle after the grant edge
  task automatic check_return(string name, logic pend, logic rvalid, data_t rdata, data_t exp);
    if (pend && rvalid !== 1'b1) begin
      $display("%s: read was granted but rvalid did not pulse one cycle later", name);
      step_errs++;
    end else if (!pend && rvalid !== 1'b0) begin
      $display("%s: rvalid pulsed with no read outstanding", name);
      step_errs++;
    end else if (pend) begin
      check_data(name, exp, rdata);
    end
  endtask

  task automatic add_step(string name, logic [1:0] cfg_op, arb_mode_t mode,
                          logic [1:0] a_op, addr_t a_addr, data_t a_data, strb_t a_be,
                          logic [1:0] b_op, addr_t b_addr, data_t b_data, strb_t b_be,
                          logic [1:0] exp_gnt);
    step_t s;
    s = '{cfg_op, mode, a_op, a_addr, a_data, a_be, b_op, b_addr, b_data, b_be, exp_gnt};
    steps.push_back(s);
    names.push_back(name);
  endtask

  task automatic build_table();
    addr_t fill_a [8];
    addr_t fill_b [8];
    // A and B always land in different banks while filling
    for (int i = 0; i < 8; i++) begin
      fill_a[i] = addr_t'($random(seed));
      fill_b[i] = addr_t'($random(seed));
      fill_a[i][1:0] = 2'b00;
      fill_b[i][1:0] = 2'b00;
      fill_a[i][BANK_OFF +: BANK_W] = bank_idx_t'(i);
      fill_b[i][BANK_OFF +: BANK_W] = bank_idx_t'(i + 2);
      add_step($sformatf("fill_wr_%0d", i), CFG_NONE, ARB_RR,
               OP_WR, fill_a[i], data_t'($random(seed)), 4'hf,
               OP_WR, fill_b[i], data_t'($random(seed)), 4'hf, 2'b11);
    end
    for (int i = 0; i < 8; i++) begin
      add_step($sformatf("fill_rd_%0d", i), CFG_NONE, ARB_RR,
               OP_RD, fill_a[i], '0, '0, OP_RD, fill_b[i], '0, '0, 2'b11);
    end
    add_step("be_full", CFG_NONE, ARB_RR, OP_WR, 11'h100, 32'h1122_3344, 4'hf,
             OP_IDLE, '0, '0, '0, 2'b10);
    add_step("be_lanes", CFG_NONE, ARB_RR, OP_WR, 11'h100, 32'haabb_ccdd, 4'b0101,
             OP_IDLE, '0, '0, '0, 2'b10);
    add_step("be_read", CFG_NONE, ARB_RR, OP_RD, 11'h100, '0, '0,
             OP_IDLE, '0, '0, '0, 2'b10);
    add_step("row0_wr", CFG_NONE, ARB_RR, OP_IDLE, '0, '0, '0,
             OP_WR, 11'h024, 32'h0000_1234, 4'hf, 2'b01);
    add_step("row1_wr", CFG_NONE, ARB_RR, OP_IDLE, '0, '0, '0,
             OP_WR, 11'h424, 32'h5678_0000, 4'hf, 2'b01);
    // first conflict after reset goes to B, then winners alternate
    add_step("rr_row_rd", CFG_NONE, ARB_RR, OP_RD, 11'h424, '0, '0,
             OP_RD, 11'h024, '0, '0, 2'b01);
    add_step("rr_second", CFG_NONE, ARB_RR, OP_WR, 11'h004, 32'hcafe_0004, 4'hf,
             OP_WR, 11'h104, 32'hbeef_0104, 4'hf, 2'b10);
    add_step("rr_third", CFG_NONE, ARB_RR, OP_RD, 11'h104, '0, '0,
             OP_RD, 11'h004, '0, '0, 2'b01);
    add_step("count_rr", CFG_COUNT, ARB_RR, OP_IDLE, '0, '0, '0,
             OP_IDLE, '0, '0, '0, 2'b00);
    add_step("fixed_a_wr", CFG_MODE, ARB_FIXED_A, OP_WR, 11'h00c, 32'h0a0a_000c, 4'hf,
             OP_WR, 11'h10c, 32'h0b0b_010c, 4'hf, 2'b10);
    add_step("fixed_a_rd", CFG_NONE, ARB_FIXED_A, OP_RD, 11'h10c, '0, '0,
             OP_RD, 11'h00c, '0, '0, 2'b10);
    add_step("fixed_b_rd", CFG_MODE, ARB_FIXED_B, OP_RD, 11'h00c, '0, '0,
             OP_RD, 11'h10c, '0, '0, 2'b01);
    add_step("fixed_b_wr", CFG_NONE, ARB_FIXED_B, OP_WR, 11'h020, 32'h1111_0020, 4'hf,
             OP_WR, 11'h420, 32'h2222_0420, 4'hf, 2'b01);
    add_step("count_fixed", CFG_COUNT, ARB_RR, OP_IDLE, '0, '0, '0,
             OP_IDLE, '0, '0, '0, 2'b00);
  endtask

  task automatic run_step(int idx);
    step_t s;
    logic  a_pend, b_pend, a_rd, b_rd, a_g, b_g;
    data_t a_exp, b_exp;
    int    a_tries, b_tries, cyc;
    s = steps[idx];
    step_errs = 0;
    if (s.cfg_op == CFG_MODE) begin
      cfg_we_i    = 1'b1;
      cfg_addr_i  = CFG_MODE_ADDR;
      cfg_wdata_i = data_t'(s.mode);
      @(posedge clk_i);
      #1;
      cfg_we_i = 1'b0;
    end else if (s.cfg_op == CFG_COUNT) begin
      cfg_addr_i = CFG_CONFLICT_ADDR;
      @(negedge clk_i);
      check_count(names[idx], data_t'(tally), cfg_rdata_o);
      @(posedge clk_i);
      #1;
      cfg_we_i = 1'b1;
      @(posedge clk_i);
      #1;
      cfg_we_i = 1'b0;
      tally    = 0;
      @(negedge clk_i);
      check_count({names[idx], "/clear"}, '0, cfg_rdata_o);
      @(posedge clk_i);
      #1;
    end
    a_pend    = (s.a_op != OP_IDLE);
    b_pend    = (s.b_op != OP_IDLE);
    a_req_i   = a_pend;
    a_we_i    = (s.a_op == OP_WR);
    a_addr_i  = s.a_addr;
    a_wdata_i = s.a_data;
    a_be_i    = s.a_be;
    b_req_i   = b_pend;
    b_we_i    = (s.b_op == OP_WR);
    b_addr_i  = s.b_addr;
    b_wdata_i = s.b_data;
    b_be_i    = s.b_be;
    a_rd      = 1'b0;
    b_rd      = 1'b0;
    a_tries   = 0;
    b_tries   = 0;
    cyc       = 0;
    while (a_pend || b_pend || a_rd || b_rd) begin
      @(negedge clk_i);
      check_return({names[idx], "/A"}, a_rd, a_rvalid_o, a_rdata_o, a_exp);
      check_return({names[idx], "/B"}, b_rd, b_rvalid_o, b_rdata_o, b_exp);
      if (cyc == 0) begin
        check_gnt(names[idx], s.exp_gnt, {a_gnt_o, b_gnt_o});
        // mode register reads back what was just written
        if (s.cfg_op == CFG_MODE) begin
          check_data({names[idx], "/mode"}, data_t'(s.mode), cfg_rdata_o);
        end
      end
      if (a_req_i && b_req_i &&
          a_addr_i[BANK_OFF +: BANK_W] == b_addr_i[BANK_OFF +: BANK_W]) begin
        tally++;
      end
      a_g = a_req_i & a_gnt_o;
      b_g = b_req_i & b_gnt_o;
      if (a_req_i && !a_gnt_o) begin
        a_tries++;
      end
      if (b_req_i && !b_gnt_o) begin
        b_tries++;
      end
      @(posedge clk_i);
      // the access happens on this edge
      a_rd  = a_g & ~a_we_i;
      b_rd  = b_g & ~b_we_i;
      a_exp = model_read(a_addr_i);
      b_exp = model_read(b_addr_i);
      if (a_g && a_we_i) begin
        model_write(a_addr_i, a_wdata_i, a_be_i);
      end
      if (b_g && b_we_i) begin
        model_write(b_addr_i, b_wdata_i, b_be_i);
      end
      #1;
      if (a_g) begin
        a_pend  = 1'b0;
        a_req_i = 1'b0;
      end
      if (b_g) begin
        b_pend  = 1'b0;
        b_req_i = 1'b0;
      end
      cyc++;
    end
    // a loser waits exactly one cycle
    check_retries({names[idx], "/A"}, int'(s.a_op != OP_IDLE && !s.exp_gnt[1]), a_tries);
    check_retries({names[idx], "/B"}, int'(s.b_op != OP_IDLE && !s.exp_gnt[0]), b_tries);
    if (step_errs == 0) begin
      $display("test %s: ok", names[idx]);
    end else begin
      $display("test %s: %0d failed check(s)", names[idx], step_errs);
      fail_tests++;
    end
  endtask

  initial begin
    seed        = 32'hff94_9f65;
    rst_n_i     = 1'b0;
    a_req_i     = 1'b0;
    a_we_i      = 1'b0;
    a_addr_i    = '0;
    a_wdata_i   = '0;
    a_be_i      = '0;
    b_req_i     = 1'b0;
    b_we_i      = 1'b0;
    b_addr_i    = '0;
    b_wdata_i   = '0;
    b_be_i      = '0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = CFG_MODE_ADDR;
    cfg_wdata_i = '0;
    build_table();
    max_cycles = 8 * steps.size() + 100;
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    for (int i = 0; i < steps.size(); i++) begin
      run_step(i);
    end
    $display("tests %0d, passed %0d, failed %0d",
             steps.size(), steps.size() - fail_tests, fail_tests);
    if (fail_tests == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: source/l2_mem.sv
// L2 scratchpad memory top level
// two requester ports into banked SRAM through a per-bank arbiter,
// with a small config block for policy and conflict statistics
`timescale 1ns/1ps

module l2_mem
  import l2_mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // port A
  input  logic      a_req_i,
  input  logic      a_we_i,
  input  addr_t     a_addr_i,
  input  data_t     a_wdata_i,
  input  strb_t     a_be_i,
  output logic      a_gnt_o,
  output logic      a_rvalid_o,
  output data_t     a_rdata_o,
  // port B
  input  logic      b_req_i,
  input  logic      b_we_i,
  input  addr_t     b_addr_i,
  input  data_t     b_wdata_i,
  input  strb_t     b_be_i,
  output logic      b_gnt_o,
  output logic      b_rvalid_o,
  output data_t     b_rdata_o,
  // config bus
  input  logic      cfg_we_i,
  input  cfg_addr_t cfg_addr_i,
  input  data_t     cfg_wdata_i,
  output data_t     cfg_rdata_o
);

  arb_mode_t               arb_mode;
  bank_vec_t               conflict;
  bank_vec_t               bank_req, bank_we;
  cut_addr_t [N_BANKS-1:0] bank_cut_addr;
  row_idx_t  [N_BANKS-1:0] bank_row;
  data_t     [N_BANKS-1:0] bank_wdata, bank_rdata;
  strb_t     [N_BANKS-1:0] bank_be;

  l2_cfg_regs i_cfg (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .conflict_i  (conflict),
    .arb_mode_o  (arb_mode)
  );

  l2_interconnect i_xbar (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .a_req_i         (a_req_i),
    .a_we_i          (a_we_i),
    .a_addr_i        (a_addr_i),
    .a_wdata_i       (a_wdata_i),
    .a_be_i          (a_be_i),
    .a_gnt_o         (a_gnt_o),
    .a_rvalid_o      (a_rvalid_o),
    .a_rdata_o       (a_rdata_o),
    .b_req_i         (b_req_i),
    .b_we_i          (b_we_i),
    .b_addr_i        (b_addr_i),
    .b_wdata_i       (b_wdata_i),
    .b_be_i          (b_be_i),
    .b_gnt_o         (b_gnt_o),
    .b_rvalid_o      (b_rvalid_o),
    .b_rdata_o       (b_rdata_o),
    .arb_mode_i      (arb_mode),
    .conflict_o      (conflict),
    .bank_req_o      (bank_req),
    .bank_we_o       (bank_we),
    .bank_cut_addr_o (bank_cut_addr),
    .bank_row_o      (bank_row),
    .bank_wdata_o    (bank_wdata),
    .bank_be_o       (bank_be),
    .bank_rdata_i    (bank_rdata)
  );

  l2_mem_bank_array i_banks (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .bank_req_i      (bank_req),
    .bank_we_i       (bank_we),
    .bank_cut_addr_i (bank_cut_addr),
    .bank_row_i      (bank_row),
    .bank_wdata_i    (bank_wdata),
    .bank_be_i       (bank_be),
    .bank_rdata_o    (bank_rdata)
  );

endmodule

// File: source/l2_cfg_regs.sv
// L2 configuration registers
// arbitration policy register and saturating bank-conflict counter
`timescale 1ns/1ps

module l2_cfg_regs
  import l2_mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      cfg_we_i,
  input  cfg_addr_t cfg_addr_i,
  input  data_t     cfg_wdata_i,
  output data_t     cfg_rdata_o,
  input  bank_vec_t conflict_i,
  output arb_mode_t arb_mode_o
);

  arb_mode_t               mode_q;
  data_t                   cnt_q;
  logic [$clog2(N_BANKS):0] n_conf;
  logic [DATA_W:0]         cnt_sum;

  // number of banks in conflict this cycle
  always_comb begin
    n_conf = '0;
    for (int k = 0; k < N_BANKS; k++) begin
      n_conf = n_conf + conflict_i[k];
    end
  end

  // carry out means the counter would wrap
  assign cnt_sum = {1'b0, cnt_q} + n_conf;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mode_q <= ARB_RR;
      cnt_q  <= '0;
    end else begin
      if (cfg_we_i && cfg_addr_i == CFG_MODE_ADDR) begin
        mode_q <= cfg_wdata_i[ARB_MODE_W-1:0];
      end
      // clear wins over counting
      if (cfg_we_i && cfg_addr_i == CFG_CONFLICT_ADDR) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_sum[DATA_W] ? '1 : cnt_sum[DATA_W-1:0];
      end
    end
  end

  assign cfg_rdata_o = (cfg_addr_i == CFG_CONFLICT_ADDR) ? cnt_q : data_t'(mode_q);
  assign arb_mode_o  = mode_q;

endmodule

// File: source/l2_mem_bank_array.sv
// L2 memory bank array
// N_BANKS columns of N_ROWS serial SRAM cuts, the row field picks
// the cut and a registered copy selects the returning read word
`timescale 1ns/1ps

module l2_mem_bank_array
  import l2_mem_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  bank_vec_t               bank_req_i,
  input  bank_vec_t               bank_we_i,
  input  cut_addr_t [N_BANKS-1:0] bank_cut_addr_i,
  input  row_idx_t  [N_BANKS-1:0] bank_row_i,
  input  data_t     [N_BANKS-1:0] bank_wdata_i,
  input  strb_t     [N_BANKS-1:0] bank_be_i,
  output data_t     [N_BANKS-1:0] bank_rdata_o
);

  logic     [N_BANKS-1:0][N_ROWS-1:0] cut_req;
  data_t    [N_BANKS-1:0][N_ROWS-1:0] cut_rdata;
  row_idx_t [N_BANKS-1:0]             row_q;

  for (genvar k = 0; k < N_BANKS; k++) begin : gen_cols

    // one-hot cut request within the column
    for (genvar r = 0; r < N_ROWS; r++) begin : gen_row_dec
      assign cut_req[k][r] = bank_req_i[k] && (bank_row_i[k] == row_idx_t'(r));
    end

    // row held until the next request so idle cycles keep the last word
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        row_q[k] <= '0;
      end else if (bank_req_i[k]) begin
        row_q[k] <= bank_row_i[k];
      end
    end

    assign bank_rdata_o[k] = cut_rdata[k][row_q[k]];

    // address and data broadcast to every cut of the column
    for (genvar r = 0; r < N_ROWS; r++) begin : gen_rows
      l2_sram_cut i_cut (
        .clk_i   (clk_i),
        .req_i   (cut_req[k][r]),
        .we_i    (bank_we_i[k]),
        .addr_i  (bank_cut_addr_i[k]),
        .wdata_i (bank_wdata_i[k]),
        .be_i    (bank_be_i[k]),
        .rdata_o (cut_rdata[k][r])
      );
    end
  end

endmodule

// File: source/l2_interconnect.sv
// L2 interconnect
// decodes the two requester ports onto word-interleaved banks,
// arbitrates each bank and steers read data back to its port
`timescale 1ns/1ps

module l2_interconnect
  import l2_mem_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // port A
  input  logic                    a_req_i,
  input  logic                    a_we_i,
  input  addr_t                   a_addr_i,
  input  data_t                   a_wdata_i,
  input  strb_t                   a_be_i,
  output logic                    a_gnt_o,
  output logic                    a_rvalid_o,
  output data_t                   a_rdata_o,
  // port B
  input  logic                    b_req_i,
  input  logic                    b_we_i,
  input  addr_t                   b_addr_i,
  input  data_t                   b_wdata_i,
  input  strb_t                   b_be_i,
  output logic                    b_gnt_o,
  output logic                    b_rvalid_o,
  output data_t                   b_rdata_o,
  // cfg block
  input  arb_mode_t               arb_mode_i,
  output bank_vec_t               conflict_o,
  // bank array
  output bank_vec_t               bank_req_o,
  output bank_vec_t               bank_we_o,
  output cut_addr_t [N_BANKS-1:0] bank_cut_addr_o,
  output row_idx_t  [N_BANKS-1:0] bank_row_o,
  output data_t     [N_BANKS-1:0] bank_wdata_o,
  output strb_t     [N_BANKS-1:0] bank_be_o,
  input  data_t     [N_BANKS-1:0] bank_rdata_i
);

  // index 0 is port A, index 1 is port B
  logic      [1:0] p_req, p_we, p_gnt, rd_d, rd_q;
  addr_t     [1:0] p_addr;
  data_t     [1:0] p_wdata;
  strb_t     [1:0] p_be;
  bank_vec_t [1:0] p_hit, p_bank_gnt;
  bank_idx_t [1:0] p_bank, rd_bank_q;
  bank_vec_t       sel_b;

  assign p_req   = {b_req_i, a_req_i};
  assign p_we    = {b_we_i, a_we_i};
  assign p_addr  = {b_addr_i, a_addr_i};
  assign p_wdata = {b_wdata_i, a_wdata_i};
  assign p_be    = {b_be_i, a_be_i};

  for (genvar p = 0; p < 2; p++) begin : gen_ports
    assign p_bank[p] = p_addr[p][BANK_OFF +: BANK_W];
    for (genvar k = 0; k < N_BANKS; k++) begin : gen_hit
      assign p_hit[p][k] = p_req[p] && (p_bank[p] == bank_idx_t'(k));
    end
    // a port targets one bank, so any bank grant is its grant
    assign p_gnt[p] = |p_bank_gnt[p];
    assign rd_d[p]  = p_gnt[p] & ~p_we[p];
  end

  for (genvar k = 0; k < N_BANKS; k++) begin : gen_banks
    l2_bank_arbiter i_arb (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .req_a_i    (p_hit[0][k]),
      .req_b_i    (p_hit[1][k]),
      .mode_i     (arb_mode_i),
      .gnt_a_o    (p_bank_gnt[0][k]),
      .gnt_b_o    (p_bank_gnt[1][k]),
      .conflict_o (conflict_o[k])
    );

    // winner fields onto the bank
    assign sel_b[k]           = p_bank_gnt[1][k];
    assign bank_req_o[k]      = p_bank_gnt[0][k] | p_bank_gnt[1][k];
    assign bank_we_o[k]       = p_we[sel_b[k]];
    assign bank_cut_addr_o[k] = p_addr[sel_b[k]][WORD_OFF +: CUT_ADDR_W];
    assign bank_row_o[k]      = p_addr[sel_b[k]][ROW_OFF +: ROW_W];
    assign bank_wdata_o[k]    = p_wdata[sel_b[k]];
    assign bank_be_o[k]       = p_be[sel_b[k]];
  end

  assign a_gnt_o = p_gnt[0];
  assign b_gnt_o = p_gnt[1];

  // read return, one cycle behind the grant
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_q <= '0;
    end else begin
      rd_q <= rd_d;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_bank_q <= p_bank;
  end

  assign a_rvalid_o = rd_q[0];
  assign b_rvalid_o = rd_q[1];
  assign a_rdata_o  = bank_rdata_i[rd_bank_q[0]];
  assign b_rdata_o  = bank_rdata_i[rd_bank_q[1]];

endmodule

// File: source/l2_bank_arbiter.sv
// L2 bank arbiter
// two-way grant for a single bank, fixed priority to either port
// or round-robin on the last conflict winner
`timescale 1ns/1ps

module l2_bank_arbiter
  import l2_mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      req_a_i,
  input  logic      req_b_i,
  input  arb_mode_t mode_i,
  output logic      gnt_a_o,
  output logic      gnt_b_o,
  output logic      conflict_o
);

  // last conflict winner, low means port A
  logic last_b_q;
  logic a_wins;

  assign conflict_o = req_a_i & req_b_i;

  // priority on a conflict
  always_comb begin
    case (mode_i)
      ARB_FIXED_A: begin
        a_wins = 1'b1;
      end
      ARB_FIXED_B: begin
        a_wins = 1'b0;
      end
      // round-robin, also taken for the unused code
      default: begin
        a_wins = last_b_q;
      end
    endcase
  end

  // a lone request always wins
  assign gnt_a_o = req_a_i & (~req_b_i | a_wins);
  assign gnt_b_o = req_b_i & (~req_a_i | ~a_wins);

  // winner history only moves on conflict cycles
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_b_q <= 1'b0;
    end else if (conflict_o) begin
      last_b_q <= ~a_wins;
    end
  end

endmodule

// File: source/l2_sram_cut.sv
// L2 SRAM cut
// behavioral single-port word memory with byte enables,
// read data registered one cycle after the request
`timescale 1ns/1ps

module l2_sram_cut
  import l2_mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      req_i,
  input  logic      we_i,
  input  cut_addr_t addr_i,
  input  data_t     wdata_i,
  input  strb_t     be_i,
  output data_t     rdata_o
);

  data_t mem_q [CUT_N_WORDS];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // only enabled byte lanes are written
        for (int i = 0; i < STRB_W; i++) begin
          if (be_i[i]) begin
            mem_q[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// File: source/l2_mem_pkg.sv
// L2 scratchpad memory package
// widths, address-field positions, arbitration codes and the
// vector types shared by the interconnect, bank array and cfg block
package l2_mem_pkg;

  // data path
  localparam int unsigned DATA_W      = 32;
  localparam int unsigned STRB_W      = DATA_W / 8;

  // array geometry
  localparam int unsigned N_BANKS     = 4;
  localparam int unsigned N_ROWS      = 2;
  localparam int unsigned CUT_N_WORDS = 64;
  localparam int unsigned ADDR_W      = 11;

  // byte address layout: | row | word in cut | bank | byte |
  localparam int unsigned BANK_OFF    = 2;
  localparam int unsigned BANK_W      = 2;
  localparam int unsigned WORD_OFF    = 4;
  localparam int unsigned CUT_ADDR_W  = 6;
  localparam int unsigned ROW_OFF     = 10;
  localparam int unsigned ROW_W       = 1;

  // config field widths
  localparam int unsigned ARB_MODE_W  = 2;
  localparam int unsigned CFG_ADDR_W  = 1;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [STRB_W-1:0]     strb_t;
  typedef logic [BANK_W-1:0]     bank_idx_t;
  typedef logic [CUT_ADDR_W-1:0] cut_addr_t;
  typedef logic [ROW_W-1:0]      row_idx_t;
  typedef logic [ARB_MODE_W-1:0] arb_mode_t;
  typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
  typedef logic [N_BANKS-1:0]    bank_vec_t;

  // arbitration policies, round-robin after reset
  localparam arb_mode_t ARB_FIXED_A = 2'd0;
  localparam arb_mode_t ARB_FIXED_B = 2'd1;
  localparam arb_mode_t ARB_RR      = 2'd2;

  // config register map
  localparam cfg_addr_t CFG_MODE_ADDR     = 1'b0;
  localparam cfg_addr_t CFG_CONFLICT_ADDR = 1'b1;

endpackage
